/* hw/fpu_pkg.sv */
package fpu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Single precision widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int W    = 32;
    localparam int EW   = 8;
    localparam int SW   = 23;
    // Hidden one, fraction, two guard bits
    localparam int SWR  = 26;
    localparam int EWR  = 5;
    localparam int BIAS = 127;

    // Exponent operand selection
    localparam logic [1:0] EXP_SEL_DIFF    = 2'd0;
    localparam logic [1:0] EXP_SEL_LZ      = 2'd1;
    localparam logic [1:0] EXP_SEL_ONE     = 2'd2;
    localparam logic [1:0] EXP_SEL_RESTORE = 2'd3;

    typedef enum logic [1:0] {
        RND_NEAREST_EVEN = 2'd0,
        RND_TO_ZERO      = 2'd1,
        RND_TO_POS       = 2'd2,
        RND_TO_NEG       = 2'd3
    } round_mode_e;

    typedef enum logic [3:0] {
        S_IDLE,
        S_LOAD,
        S_CLASSIFY,
        S_EXP_DIFF,
        S_ALIGN,
        S_ADD,
        S_NORM,
        S_NORM_EXP,
        S_ROUND_CHECK,
        S_ROUND_ADD,
        S_PACK,
        S_DONE
    } fsm_state_e;

endpackage

/* hw/exp_operation.sv */
module exp_operation (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    load_i,
    input  logic [1:0]              sel_i,
    input  logic                    sub_i,
    input  logic [fpu_pkg::EW-1:0]  exp_big_i,
    input  logic [fpu_pkg::EW-1:0]  exp_small_i,
    input  logic [fpu_pkg::EWR-1:0] lz_count_i,
    output logic [fpu_pkg::EW-1:0]  exp_o,
    output logic                    overflow_o,
    output logic                    underflow_o
);
    import fpu_pkg::*;

    logic [EW-1:0] oper_a, oper_b;
    // Two extra bits keep sign and carry
    logic [EW+1:0] res;

    always_comb begin
        oper_a = (sel_i == EXP_SEL_DIFF) ? exp_big_i : exp_o;
        case (sel_i)
            EXP_SEL_LZ:  oper_b = EW'(lz_count_i);
            EXP_SEL_ONE: oper_b = EW'(1);
            default:     oper_b = exp_small_i;
        endcase
        if (sub_i) begin
            res = {2'b00, oper_a} - {2'b00, oper_b};
        end else begin
            res = {2'b00, oper_a} + {2'b00, oper_b};
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exp_o       <= '0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else if (load_i) begin
            exp_o <= res[EW-1:0];
            // A difference is a shift amount, no flags
            if (sel_i == EXP_SEL_DIFF) begin
                overflow_o  <= 1'b0;
                underflow_o <= 1'b0;
            end else begin
                overflow_o  <= !res[EW+1] && (res[EW:0] >= (EW+1)'(2 * BIAS + 1));
                underflow_o <= res[EW+1] || (res == '0);
            end
        end
    end

endmodule

/* hw/barrel_shifter.sv */
module barrel_shifter (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    load_i,
    input  logic                    left_i,
    input  logic                    src_i,
    input  logic [fpu_pkg::EW-1:0]  amount_i,
    input  logic [fpu_pkg::EWR-1:0] lz_i,
    input  logic [fpu_pkg::W-2:0]   small_sgf_i,
    input  logic [fpu_pkg::SWR-1:0] sum_i,
    output logic [fpu_pkg::SWR-1:0] sgf_o
);
    import fpu_pkg::*;

    logic [SWR-1:0] data;
    logic [EWR-1:0] amt;
    logic           hidden;

    // Hidden one only for a nonzero exponent
    assign hidden = |small_sgf_i[W-2:SW];

    always_comb begin
        if (!src_i) begin
            // Alignment of the smaller operand
            data = {hidden, small_sgf_i[SW-1:0], 2'b00};
            amt  = amount_i[EWR-1:0];
        end else if (left_i) begin
            data = sum_i;
            amt  = lz_i;
        end else begin
            // Right normalize only on carry, carry moves in on top
            data = {1'b1, sum_i[SWR-1:1]};
            amt  = '0;
        end
        // Log stages of 1, 2, 4, 8, 16
        for (int k = 0; k < EWR; k++) begin
            if (amt[k]) begin
                data = left_i ? (data << (1 << k)) : (data >> (1 << k));
            end
        end
        if (!src_i && amount_i >= EW'(SWR)) begin
            data = '0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sgf_o <= '0;
        end else if (load_i) begin
            sgf_o <= data;
        end
    end

endmodule

/* hw/sgf_add_subt.sv */
module sgf_add_subt (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    load_i,
    input  logic                    sub_i,
    input  logic                    round_i,
    input  logic [fpu_pkg::SW-1:0]  big_sgf_i,
    input  logic [fpu_pkg::SWR-1:0] shifted_i,
    output logic [fpu_pkg::SWR-1:0] sum_o,
    output logic                    carry_o,
    output logic [fpu_pkg::EWR-1:0] lz_count_o
);
    import fpu_pkg::*;

    logic [SWR-1:0] oper_a, oper_b;
    logic [SWR:0]   res;

    ////////////////////////////////////////////////////////////////////////////
    // Operand selection and add
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (round_i) begin
            // Increment at the LSB above the guard bits
            oper_a = shifted_i;
            oper_b = SWR'(4);
        end else begin
            oper_a = {1'b1, big_sgf_i, 2'b00};
            oper_b = shifted_i;
        end
        // Larger minus smaller never borrows
        if (sub_i && !round_i) begin
            res = {1'b0, oper_a} - {1'b0, oper_b};
        end else begin
            res = {1'b0, oper_a} + {1'b0, oper_b};
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sum_o   <= '0;
            carry_o <= 1'b0;
        end else if (load_i) begin
            sum_o   <= res[SWR-1:0];
            carry_o <= res[SWR];
        end
    end

    // Leading zeros of the held sum, highest set bit wins
    always_comb begin
        lz_count_o = '0;
        for (int i = 0; i < SWR; i++) begin
            if (sum_o[i]) begin
                lz_count_o = EWR'(SWR - 1 - i);
            end
        end
    end

endmodule

/* hw/oper_start_in.sv */
module oper_start_in (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   load_in_i,
    input  logic                   load_cls_i,
    input  logic [fpu_pkg::W-1:0]  data_x_i,
    input  logic [fpu_pkg::W-1:0]  data_y_i,
    input  logic                   add_subt_i,
    input  fpu_pkg::round_mode_e   r_mode_i,
    output logic [fpu_pkg::W-2:0]  dmp_o,
    output logic [fpu_pkg::W-2:0]  dmin_o,
    output logic                   real_op_o,
    output logic                   sign_o,
    output logic                   zero_o
);
    import fpu_pkg::*;

    logic [W-1:0] x_q, y_q;
    logic         as_q;
    logic [W-2:0] mag_x, mag_y;
    logic         sign_y_eff, op_sub, x_big, cancel;

    // Operand capture
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            x_q  <= '0;
            y_q  <= '0;
            as_q <= 1'b0;
        end else if (load_in_i) begin
            x_q  <= data_x_i;
            y_q  <= data_y_i;
            as_q <= add_subt_i;
        end
    end

    // Zero exponent field means zero, fraction ignored
    assign mag_x      = (x_q[W-2:SW] == '0) ? '0 : x_q[W-2:0];
    assign mag_y      = (y_q[W-2:SW] == '0) ? '0 : y_q[W-2:0];
    assign sign_y_eff = y_q[W-1] ^ as_q;
    assign op_sub     = x_q[W-1] ^ sign_y_eff;
    assign x_big      = (mag_x >= mag_y);
    assign cancel     = op_sub && (mag_x == mag_y);

    ////////////////////////////////////////////////////////////////////////////
    // Classification register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dmp_o     <= '0;
            dmin_o    <= '0;
            real_op_o <= 1'b0;
            sign_o    <= 1'b0;
            zero_o    <= 1'b0;
        end else if (load_cls_i) begin
            dmp_o     <= x_big ? mag_x : mag_y;
            dmin_o    <= x_big ? mag_y : mag_x;
            real_op_o <= op_sub;
            zero_o    <= cancel || (mag_x == '0 && mag_y == '0);
            // Exact cancellation is negative only toward minus infinity
            if (cancel) begin
                sign_o <= (r_mode_i == RND_TO_NEG);
            end else begin
                sign_o <= x_big ? x_q[W-1] : sign_y_eff;
            end
        end
    end

endmodule

/* hw/result_pack.sv */
module result_pack (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    load_i,
    input  logic                    sign_i,
    input  logic [fpu_pkg::EW-1:0]  exp_i,
    input  logic [fpu_pkg::SWR-1:0] sgf_i,
    input  logic                    zero_i,
    input  logic                    overflow_i,
    input  logic                    underflow_i,
    output logic [fpu_pkg::W-1:0]   result_o
);
    import fpu_pkg::*;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
        end else if (load_i) begin
            if (zero_i || underflow_i) begin
                // Signed zero, subnormals flushed
                result_o <= {sign_i, {(W-1){1'b0}}};
            end else if (overflow_i) begin
                // Signed infinity
                result_o <= {sign_i, {EW{1'b1}}, {SW{1'b0}}};
            end else begin
                // Hidden one and guard bits dropped
                result_o <= {sign_i, exp_i, sgf_i[SWR-2:2]};
            end
        end
    end

endmodule

/* hw/fpu_ctrl_fsm.sv */
module fpu_ctrl_fsm (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    beg_i,
    input  logic                    ack_i,
    input  fpu_pkg::round_mode_e    r_mode_i,
    input  logic                    zero_i,
    input  logic                    carry_i,
    input  logic [fpu_pkg::EWR-1:0] lz_count_i,
    input  logic [1:0]              guard_i,
    input  logic                    lsb_i,
    input  logic                    sign_i,
    output logic                    load_in_o,
    output logic                    load_cls_o,
    output logic                    exp_load_o,
    output logic [1:0]              exp_sel_o,
    output logic                    exp_sub_o,
    output logic                    shift_load_o,
    output logic                    shift_left_o,
    output logic                    shift_src_o,
    output logic                    add_load_o,
    output logic                    add_round_o,
    output logic                    pack_load_o,
    output logic                    ready_o
);
    import fpu_pkg::*;

    fsm_state_e state_q, state_d;
    // Set once the rounding increment went through the adder
    logic       rounded_q;
    logic       round_up;
    logic       lz_zero;

    assign lz_zero = (lz_count_i == '0);

    // Rounding decoder
    always_comb begin
        case (r_mode_i)
            RND_NEAREST_EVEN: round_up = guard_i[1] & (guard_i[0] | lsb_i);
            RND_TO_POS:       round_up = (guard_i != 2'b00) & ~sign_i;
            RND_TO_NEG:       round_up = (guard_i != 2'b00) & sign_i;
            default:          round_up = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= S_IDLE;
            rounded_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == S_IDLE) begin
                rounded_q <= 1'b0;
            end else if (state_q == S_ROUND_ADD) begin
                rounded_q <= 1'b1;
            end
        end
    end

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:        if (beg_i) state_d = S_LOAD;
            S_LOAD:        state_d = S_CLASSIFY;
            S_CLASSIFY:    state_d = zero_i ? S_PACK : S_EXP_DIFF;
            S_EXP_DIFF:    state_d = S_ALIGN;
            S_ALIGN:       state_d = S_ADD;
            S_ADD:         state_d = S_NORM;
            // Rounded sum without carry is already normalized
            S_NORM:        state_d = (rounded_q && !carry_i) ? S_PACK : S_NORM_EXP;
            S_NORM_EXP:    state_d = rounded_q ? S_PACK : S_ROUND_CHECK;
            S_ROUND_CHECK: state_d = round_up ? S_ROUND_ADD : S_PACK;
            S_ROUND_ADD:   state_d = S_NORM;
            S_PACK:        state_d = S_DONE;
            S_DONE:        if (ack_i) state_d = S_IDLE;
            default:       state_d = S_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Strobes decoded from state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        load_in_o    = (state_q == S_IDLE) & beg_i;
        load_cls_o   = (state_q == S_LOAD);
        exp_load_o   = 1'b0;
        exp_sel_o    = EXP_SEL_DIFF;
        exp_sub_o    = 1'b0;
        shift_load_o = 1'b0;
        shift_left_o = 1'b0;
        shift_src_o  = 1'b0;
        add_load_o   = 1'b0;
        add_round_o  = 1'b0;
        pack_load_o  = (state_q == S_PACK);
        ready_o      = (state_q == S_DONE);
        case (state_q)
            // Zero path still clears the exponent flags
            S_CLASSIFY: begin
                exp_load_o = zero_i;
                exp_sub_o  = 1'b1;
            end
            S_EXP_DIFF: begin
                exp_load_o = 1'b1;
                exp_sub_o  = 1'b1;
            end
            S_ALIGN: shift_load_o = 1'b1;
            // Exponent back to the larger one while adding
            S_ADD: begin
                add_load_o = 1'b1;
                exp_load_o = 1'b1;
                exp_sel_o  = EXP_SEL_RESTORE;
            end
            S_NORM: begin
                shift_load_o = 1'b1;
                shift_src_o  = 1'b1;
                shift_left_o = ~carry_i;
            end
            S_NORM_EXP: begin
                exp_load_o = carry_i | ~lz_zero;
                exp_sel_o  = carry_i ? EXP_SEL_ONE : EXP_SEL_LZ;
                exp_sub_o  = ~carry_i;
            end
            S_ROUND_ADD: begin
                add_load_o  = 1'b1;
                add_round_o = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* hw/fpu_add_subtract.sv */
module fpu_add_subtract (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   beg_i,
    input  logic                   ack_i,
    input  logic [fpu_pkg::W-1:0]  data_x_i,
    input  logic [fpu_pkg::W-1:0]  data_y_i,
    input  logic                   add_subt_i,
    input  fpu_pkg::round_mode_e   r_mode_i,
    output logic                   ready_o,
    output logic [fpu_pkg::W-1:0]  final_result_o,
    output logic                   overflow_o,
    output logic                   underflow_o
);
    import fpu_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Controller strobes
    ////////////////////////////////////////////////////////////////////////////

    logic           load_in, load_cls;
    logic           exp_load, exp_sub;
    logic [1:0]     exp_sel;
    logic           shift_load, shift_left, shift_src;
    logic           add_load, add_round;
    logic           pack_load;

    // Datapath status and payload
    logic [W-2:0]   dmp, dmin;
    logic           real_op, sign_result, zero_flag;
    logic [EW-1:0]  exp_q;
    logic [SWR-1:0] sgf_norm, sum;
    logic           carry;
    logic [EWR-1:0] lz_count;

    fpu_ctrl_fsm i_ctrl (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .beg_i        (beg_i),
        .ack_i        (ack_i),
        .r_mode_i     (r_mode_i),
        .zero_i       (zero_flag),
        .carry_i      (carry),
        .lz_count_i   (lz_count),
        .guard_i      (sgf_norm[1:0]),
        .lsb_i        (sgf_norm[2]),
        .sign_i       (sign_result),
        .load_in_o    (load_in),
        .load_cls_o   (load_cls),
        .exp_load_o   (exp_load),
        .exp_sel_o    (exp_sel),
        .exp_sub_o    (exp_sub),
        .shift_load_o (shift_load),
        .shift_left_o (shift_left),
        .shift_src_o  (shift_src),
        .add_load_o   (add_load),
        .add_round_o  (add_round),
        .pack_load_o  (pack_load),
        .ready_o      (ready_o)
    );

    oper_start_in i_oper (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .load_in_i  (load_in),
        .load_cls_i (load_cls),
        .data_x_i   (data_x_i),
        .data_y_i   (data_y_i),
        .add_subt_i (add_subt_i),
        .r_mode_i   (r_mode_i),
        .dmp_o      (dmp),
        .dmin_o     (dmin),
        .real_op_o  (real_op),
        .sign_o     (sign_result),
        .zero_o     (zero_flag)
    );

    // Exponent field sits above the fraction
    exp_operation i_exp (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .load_i      (exp_load),
        .sel_i       (exp_sel),
        .sub_i       (exp_sub),
        .exp_big_i   (dmp[W-2:SW]),
        .exp_small_i (dmin[W-2:SW]),
        .lz_count_i  (lz_count),
        .exp_o       (exp_q),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o)
    );

    barrel_shifter i_shift (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .load_i      (shift_load),
        .left_i      (shift_left),
        .src_i       (shift_src),
        .amount_i    (exp_q),
        .lz_i        (lz_count),
        .small_sgf_i (dmin),
        .sum_i       (sum),
        .sgf_o       (sgf_norm)
    );

    sgf_add_subt i_add (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .load_i     (add_load),
        .sub_i      (real_op),
        .round_i    (add_round),
        .big_sgf_i  (dmp[SW-1:0]),
        .shifted_i  (sgf_norm),
        .sum_o      (sum),
        .carry_o    (carry),
        .lz_count_o (lz_count)
    );

    result_pack i_pack (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .load_i      (pack_load),
        .sign_i      (sign_result),
        .exp_i       (exp_q),
        .sgf_i       (sgf_norm),
        .zero_i      (zero_flag),
        .overflow_i  (overflow_o),
        .underflow_i (underflow_o),
        .result_o    (final_result_o)
    );

endmodule

/* verif/fpu_add_subtract_assert.sv */
module fpu_add_subtract_assert (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   ack_i,
    input  logic                   ready_i,
    input  logic [fpu_pkg::W-1:0]  result_i,
    input  logic                   overflow_i,
    input  logic                   underflow_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import fpu_pkg::*;

    // Ready held until the acknowledge is seen
    ready_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ready_i && !ack_i |=> ready_i)
        else $error("ready_o fell before ack_i was seen");

    // Result and flags frozen while waiting for ack
    result_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ready_i && !ack_i |=> $stable(result_i) && $stable(overflow_i) && $stable(underflow_i))
        else $error("result or flags changed while ready_o was high");

    // Flags exclusive and matched by the packed result word
    flags_consistent: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(overflow_i && underflow_i)
        && (!(ready_i && overflow_i) || result_i[W-2:0] == {{EW{1'b1}}, {SW{1'b0}}})
        && (!(ready_i && underflow_i) || result_i[W-2:0] == '0))
        else $error("overflow_o and underflow_o both high or not matching the result");

endmodule

bind fpu_add_subtract fpu_add_subtract_assert i_assert (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .ack_i       (ack_i),
    .ready_i     (ready_o),
    .result_i    (final_result_o),
    .overflow_i  (overflow_o),
    .underflow_i (underflow_o)
);

/* verif/tb_fpu_add_subtract.sv */
module tb_fpu_add_subtract;
    timeunit 1ns;
    timeprecision 1ps;
    import fpu_pkg::*;

    localparam int MAX_CASES       = 64;
    localparam int COLS            = 6;
    localparam int CYCLES_PER_CASE = 20;
    localparam int CYCLE_MARGIN    = 20;

    logic           clk_i, arst_n_i;
    logic           beg_i, ack_i, add_subt_i;
    logic [W-1:0]   data_x_i, data_y_i;
    round_mode_e    r_mode_i;
    logic           ready_o, overflow_o, underflow_o;
    logic [W-1:0]   final_result_o;

    // Six hex words per case as laid out in the case file
    logic [31:0]    case_mem [0:MAX_CASES*COLS-1];
    int             n_cases, errors, checks;
    int             cycle_count, cycle_limit;

    fpu_add_subtract i_dut (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .beg_i          (beg_i),
        .ack_i          (ack_i),
        .data_x_i       (data_x_i),
        .data_y_i       (data_y_i),
        .add_subt_i     (add_subt_i),
        .r_mode_i       (r_mode_i),
        .ready_o        (ready_o),
        .final_result_o (final_result_o),
        .overflow_o     (overflow_o),
        .underflow_o    (underflow_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [W-1:0] got,
                               input logic [W-1:0] expected, input int idx);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("** Error at %0d ns: case %0d %s is %h, expected %h",
                     $time, idx, what, got, expected);
        end
    endtask

    task automatic check_handshake(input logic cond, input string msg);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("Handshake failure at %0d ns: %s", $time, msg);
        end
    endtask

    // Index of the end marker line or zero without one
    function automatic int count_cases();
        for (int i = 0; i < MAX_CASES; i++) begin
            if (case_mem[i*COLS] === 32'hffff_ffff && case_mem[i*COLS+2] === 32'hf) begin
                return i;
            end
        end
        return 0;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Driver
    ////////////////////////////////////////////////////////////////////////////

    task automatic start_op(input logic [W-1:0] x, input logic [W-1:0] y,
                            input logic op, input round_mode_e mode);
        @(posedge clk_i);
        data_x_i   <= x;
        data_y_i   <= y;
        add_subt_i <= op;
        r_mode_i   <= mode;
        beg_i      <= 1'b1;
        @(posedge clk_i);
        // Busy now, so new operands and beg_i must be ignored
        data_x_i   <= ~x;
        data_y_i   <= ~y;
        @(posedge clk_i);
        beg_i      <= 1'b0;
    endtask

    // Outputs sampled on the falling edge
    task automatic wait_ready();
        @(negedge clk_i);
        while (ready_o !== 1'b1) begin
            @(negedge clk_i);
        end
    endtask

    task automatic acknowledge();
        @(posedge clk_i);
        ack_i <= 1'b1;
        @(posedge clk_i);
        ack_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic run_case(input int idx);
        logic [W-1:0] x, y, res_exp;
        logic         op;
        round_mode_e  mode;
        logic [1:0]   flags;
        x       = case_mem[idx*COLS];
        y       = case_mem[idx*COLS+1];
        op      = case_mem[idx*COLS+2][0];
        mode    = round_mode_e'(case_mem[idx*COLS+3][1:0]);
        res_exp = case_mem[idx*COLS+4];
        flags   = case_mem[idx*COLS+5][1:0];
        start_op(x, y, op, mode);
        wait_ready();
        check_value("result", final_result_o, res_exp, idx);
        check_value("overflow_o", {31'b0, overflow_o}, {31'b0, flags[1]}, idx);
        check_value("underflow_o", {31'b0, underflow_o}, {31'b0, flags[0]}, idx);
        // One more cycle without ack
        @(negedge clk_i);
        check_handshake(ready_o, "ready_o dropped before ack_i");
        check_value("held result", final_result_o, res_exp, idx);
        acknowledge();
        check_handshake(!ready_o, "ready_o still high after ack_i");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and timeout
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        arst_n_i   = 1'b0;
        beg_i      = 1'b0;
        ack_i      = 1'b0;
        add_subt_i = 1'b0;
        data_x_i   = '0;
        data_y_i   = '0;
        r_mode_i   = RND_NEAREST_EVEN;
        errors     = 0;
        checks     = 0;
        $readmemh("verif/fpu_cases.txt", case_mem);
        n_cases     = count_cases();
        cycle_limit = CYCLES_PER_CASE * n_cases + CYCLE_MARGIN;
        if (n_cases == 0) begin
            errors++;
            $display("No test cases found in verif/fpu_cases.txt");
        end
        // Reset for three cycles
        repeat (3) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        check_handshake(!ready_o, "ready_o high after reset");
        check_handshake(final_result_o === '0 && !overflow_o && !underflow_o,
                        "result or flags not cleared by reset");
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end
        $display("Cases: %0d, checks: %0d, errors: %0d", n_cases, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Limit waits for the case count
    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_count);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* flist.f */
hw/fpu_pkg.sv
hw/exp_operation.sv
hw/barrel_shifter.sv
hw/sgf_add_subt.sv
hw/oper_start_in.sv
hw/result_pack.sv
hw/fpu_ctrl_fsm.sv
hw/fpu_add_subtract.sv
verif/fpu_add_subtract_assert.sv
verif/tb_fpu_add_subtract.sv

/* verif/fpu_cases.txt */
// Columns x operand, y operand, op (1 subtracts), rounding mode, expected result, flags
// Mode 0 nearest even, 1 to zero, 2 to +inf, 3 to -inf; flags are {overflow, underflow}
3f800000 3f800000 0 0 40000000 0
40400000 40a00000 0 0 41000000 0
3f800000 3f000000 0 0 3fc00000 0
40400000 40400000 0 2 40c00000 0
// Effective subtraction with leading zeros
3f800000 3f400000 1 0 3e800000 0
3f800000 40400000 1 0 c0000000 0
3f800000 33800000 1 0 3f7fffff 0
// One pair in every mode, rounding carry renormalizes
3fffffff 33800000 0 0 40000000 0
3fffffff 33800000 0 1 3fffffff 0
3fffffff 33800000 0 2 40000000 0
3fffffff 33800000 0 3 3fffffff 0
bfffffff b3800000 0 2 bfffffff 0
bfffffff b3800000 0 3 c0000000 0
3f800000 3e800003 0 0 3fa00001 0
3f800000 33800000 0 0 3f800000 0
// Exact cancellation and zero operands
40400000 40400000 1 0 00000000 0
40400000 40400000 1 3 80000000 0
3f800000 bf800000 0 3 80000000 0
00000000 40200000 0 0 40200000 0
00400000 3f800000 1 1 bf800000 0
// Overflow and underflow
7f7fffff 7f7fffff 0 0 7f800000 2
ff7fffff ff7fffff 0 1 ff800000 2
00800001 00800000 1 0 00000000 1
// End marker
ffffffff ffffffff f f ffffffff f
